// ==== design/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

    // ------------------------------------------------
    // Widths and constants
    // ------------------------------------------------
    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned SHAMT_W    = 5;

    localparam logic [XLEN-1:0] PC_INC = XLEN'(4);  // Link address step

    // ------------------------------------------------
    // Instruction encodings
    // ------------------------------------------------
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LOAD   = 7'b0000011,  // Recognised only to be rejected
        STORE  = 7'b0100011
    } opcode_e;

    // Arithmetic funct3
    localparam logic [2:0] ADD_SUB = 3'b000;
    localparam logic [2:0] SLL     = 3'b001;
    localparam logic [2:0] SLT     = 3'b010;
    localparam logic [2:0] SLTU    = 3'b011;
    localparam logic [2:0] XOR     = 3'b100;
    localparam logic [2:0] SRL_SRA = 3'b101;
    localparam logic [2:0] OR      = 3'b110;
    localparam logic [2:0] AND     = 3'b111;

    // Branch funct3
    localparam logic [2:0] BEQ  = 3'b000;
    localparam logic [2:0] BNE  = 3'b001;
    localparam logic [2:0] BLT  = 3'b100;
    localparam logic [2:0] BGE  = 3'b101;
    localparam logic [2:0] BLTU = 3'b110;
    localparam logic [2:0] BGEU = 3'b111;

    localparam logic [6:0] FN7_BASE = 7'b0000000;
    localparam logic [6:0] FN7_ALT  = 7'b0100000;  // SUB and SRA

    // ------------------------------------------------
    // Control encodings
    // ------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_cond_e;

    typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} op_a_sel_e;

    typedef enum logic [2:0] {
        OPB_RS2, OPB_IMM_I, OPB_IMM_B, OPB_IMM_U, OPB_IMM_J
    } op_b_sel_e;

    typedef enum logic [1:0] {RD_ALU, RD_LINK, RD_IMM_U} rd_src_e;

    // ------------------------------------------------
    // Stage structs
    // ------------------------------------------------
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        opcode_e               opcode;
        logic [2:0]            funct3;
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [XLEN-1:0]       imm_i;
        logic [XLEN-1:0]       imm_b;
        logic [XLEN-1:0]       imm_u;
        logic [XLEN-1:0]       imm_j;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
    } exec_in_t;

    typedef struct packed {
        alu_op_e   alu_op;
        br_cond_e  br_cond;
        op_a_sel_e op_a_sel;
        op_b_sel_e op_b_sel;
        rd_src_e   rd_src;
        logic      rd_write;
        logic      is_branch;
        logic      is_jump;
        logic      is_jalr;   // Target bit 0 cleared
    } exec_ctrl_t;

    typedef struct packed {
        logic                  branch_en;
        logic [XLEN-1:0]       branch_addr;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  rd_write_en;
        logic [XLEN-1:0]       rd_data;
    } exec_result_t;

endpackage

`default_nettype wire

// ==== design/exec_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_decode (
    input  rv_exec_pkg::opcode_e    opcode_i,  // Major opcode
    input  logic [2:0]              funct3_i,
    input  logic [6:0]              funct7_i,
    output rv_exec_pkg::exec_ctrl_t ctrl_o
);
    import rv_exec_pkg::*;

    logic fn7_base;
    logic fn7_alt;
    logic alt_allowed;  // Only ADD/SUB and SRL/SRA take the alternate
    logic imm_shift;

    // OP and OP_IMM share the funct3 mapping
    function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            SLL:     op = ALU_SLL;
            SLT:     op = ALU_SLT;
            SLTU:    op = ALU_SLTU;
            XOR:     op = ALU_XOR;
            SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            OR:      op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign fn7_base    = (funct7_i == FN7_BASE);
    assign fn7_alt     = (funct7_i == FN7_ALT);
    assign alt_allowed = (funct3_i == ADD_SUB) || (funct3_i == SRL_SRA);
    assign imm_shift   = (funct3_i == SLL) || (funct3_i == SRL_SRA);

    always_comb
    begin
        ctrl_o          = '0;        // Rejected encoding unless set below
        ctrl_o.op_a_sel = OPA_ZERO;
        case (opcode_i)
            OP:
            begin
                ctrl_o.op_a_sel = OPA_RS1;
                ctrl_o.op_b_sel = OPB_RS2;
                ctrl_o.alu_op   = arith_op(funct3_i, fn7_alt);
                ctrl_o.rd_write = fn7_base || (fn7_alt && alt_allowed);
            end
            OP_IMM:
            begin
                ctrl_o.op_a_sel = OPA_RS1;
                ctrl_o.op_b_sel = OPB_IMM_I;
                // funct7 is part of the immediate except for shifts
                ctrl_o.alu_op   = arith_op(funct3_i, imm_shift && fn7_alt);
                ctrl_o.rd_write = !imm_shift || fn7_base ||
                                  (fn7_alt && (funct3_i == SRL_SRA));
            end
            BRANCH:
            begin
                ctrl_o.op_a_sel  = OPA_PC;     // Target is pc + imm_b
                ctrl_o.op_b_sel  = OPB_IMM_B;
                ctrl_o.is_branch = 1'b1;
                case (funct3_i)
                    BEQ:     ctrl_o.br_cond = BR_EQ;
                    BNE:     ctrl_o.br_cond = BR_NE;
                    BLT:     ctrl_o.br_cond = BR_LT;
                    BGE:     ctrl_o.br_cond = BR_GE;
                    BLTU:    ctrl_o.br_cond = BR_LTU;
                    BGEU:    ctrl_o.br_cond = BR_GEU;
                    default: ctrl_o.is_branch = 1'b0;
                endcase
            end
            LUI:
            begin
                ctrl_o.op_b_sel = OPB_IMM_U;
                ctrl_o.rd_src   = RD_IMM_U;
                ctrl_o.rd_write = 1'b1;
            end
            AUIPC:
            begin
                ctrl_o.op_a_sel = OPA_PC;
                ctrl_o.op_b_sel = OPB_IMM_U;
                ctrl_o.rd_write = 1'b1;
            end
            JAL:
            begin
                ctrl_o.op_a_sel = OPA_PC;
                ctrl_o.op_b_sel = OPB_IMM_J;
                ctrl_o.rd_src   = RD_LINK;
                ctrl_o.rd_write = 1'b1;
                ctrl_o.is_jump  = 1'b1;
            end
            JALR:
            begin
                ctrl_o.op_a_sel = OPA_RS1;
                ctrl_o.op_b_sel = OPB_IMM_I;
                ctrl_o.rd_src   = RD_LINK;
                ctrl_o.rd_write = (funct3_i == 3'b000);
                ctrl_o.is_jump  = (funct3_i == 3'b000);
                ctrl_o.is_jalr  = 1'b1;
            end
            default: ;                         // LOAD, STORE and unknown
        endcase
    end

endmodule

`default_nettype wire

// ==== design/exec_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  rv_exec_pkg::alu_op_e             alu_op_i,
    input  rv_exec_pkg::br_cond_e            br_cond_i,
    input  logic [rv_exec_pkg::XLEN-1:0]     op_a_i,
    input  logic [rv_exec_pkg::XLEN-1:0]     op_b_i,
    input  logic [rv_exec_pkg::XLEN-1:0]     cmp_a_i,   // Branch compare operands
    input  logic [rv_exec_pkg::XLEN-1:0]     cmp_b_i,
    output logic [rv_exec_pkg::XLEN-1:0]     result_o,
    output logic                             cond_o     // Branch condition holds
);
    import rv_exec_pkg::*;

    logic              sub_en;
    logic [XLEN-1:0]   add_b;
    logic [XLEN-1:0]   sum;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]   sll_res;
    logic [XLEN-1:0]   srl_res;
    logic [XLEN-1:0]   sra_res;
    logic              lt_s;
    logic              lt_u;
    logic              cmp_eq;
    logic              cmp_lt;
    logic              cmp_ltu;

    // ------------------------------------------------
    // Adder and shifter
    // ------------------------------------------------
    assign sub_en = (alu_op_i == ALU_SUB);
    assign add_b  = sub_en ? ~op_b_i : op_b_i;
    assign sum    = op_a_i + add_b + XLEN'(sub_en);  // Two's complement subtract

    assign shamt   = op_b_i[SHAMT_W-1:0];
    assign sll_res = op_a_i << shamt;
    assign srl_res = op_a_i >> shamt;
    assign sra_res = $signed(op_a_i) >>> shamt;

    assign lt_s = $signed(op_a_i) < $signed(op_b_i);
    assign lt_u = op_a_i < op_b_i;

    always_comb
    begin
        case (alu_op_i)
            ALU_ADD,
            ALU_SUB:  result_o = sum;
            ALU_SLL:  result_o = sll_res;
            ALU_SRL:  result_o = srl_res;
            ALU_SRA:  result_o = sra_res;
            ALU_SLT:  result_o = XLEN'(lt_s);
            ALU_SLTU: result_o = XLEN'(lt_u);
            ALU_XOR:  result_o = op_a_i ^ op_b_i;
            ALU_OR:   result_o = op_a_i | op_b_i;
            ALU_AND:  result_o = op_a_i & op_b_i;
            default:  result_o = '0;
        endcase
    end

    // ------------------------------------------------
    // Branch comparator
    // ------------------------------------------------
    // Runs beside the adder so target and decision settle together
    assign cmp_eq  = (cmp_a_i == cmp_b_i);
    assign cmp_lt  = $signed(cmp_a_i) < $signed(cmp_b_i);
    assign cmp_ltu = cmp_a_i < cmp_b_i;

    always_comb
    begin
        case (br_cond_i)
            BR_EQ:   cond_o = cmp_eq;
            BR_NE:   cond_o = !cmp_eq;
            BR_LT:   cond_o = cmp_lt;
            BR_GE:   cond_o = !cmp_lt;
            BR_LTU:  cond_o = cmp_ltu;
            BR_GEU:  cond_o = !cmp_ltu;
            default: cond_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/exec_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_datapath (
    input  rv_exec_pkg::exec_in_t     instr_i,
    input  rv_exec_pkg::exec_ctrl_t   ctrl_i,
    output rv_exec_pkg::exec_result_t result_o  // Unregistered
);
    import rv_exec_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic            cond;
    logic [XLEN-1:0] target;

    // ------------------------------------------------
    // Operand selection
    // ------------------------------------------------
    always_comb
    begin
        case (ctrl_i.op_a_sel)
            OPA_RS1: op_a = instr_i.rs1_data;
            OPA_PC:  op_a = instr_i.pc;
            default: op_a = '0;
        endcase
        case (ctrl_i.op_b_sel)
            OPB_IMM_I: op_b = instr_i.imm_i;
            OPB_IMM_B: op_b = instr_i.imm_b;
            OPB_IMM_U: op_b = instr_i.imm_u;
            OPB_IMM_J: op_b = instr_i.imm_j;
            default:   op_b = instr_i.rs2_data;
        endcase
    end

    exec_alu u_alu (
        .alu_op_i  (ctrl_i.alu_op),
        .br_cond_i (ctrl_i.br_cond),
        .op_a_i    (op_a),
        .op_b_i    (op_b),
        .cmp_a_i   (instr_i.rs1_data),
        .cmp_b_i   (instr_i.rs2_data),
        .result_o  (alu_result),
        .cond_o    (cond)
    );

    // ------------------------------------------------
    // Result and branch
    // ------------------------------------------------
    assign target = {alu_result[XLEN-1:1], alu_result[0] & !ctrl_i.is_jalr};

    always_comb
    begin
        result_o.branch_en   = ctrl_i.is_jump || (ctrl_i.is_branch && cond);
        result_o.branch_addr = result_o.branch_en ? target : '0;
        result_o.rd_addr     = instr_i.rd_addr;     // x0 passes through too
        result_o.rd_write_en = ctrl_i.rd_write;
        case (ctrl_i.rd_src)
            RD_LINK:  result_o.rd_data = instr_i.pc + PC_INC;
            RD_IMM_U: result_o.rd_data = instr_i.imm_u;
            default:  result_o.rd_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/exec_stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_stage_reg #(
    parameter int unsigned RESET_SETTLE_CYCLES = 2
) (
    input  logic                      clk_i,
    input  logic                      resetn_i,
    input  logic                      halt_i,    // Drops the write of this item
    input  rv_exec_pkg::exec_result_t result_i,
    output rv_exec_pkg::exec_result_t result_o
);
    import rv_exec_pkg::*;

    localparam int unsigned CNT_W =
        (RESET_SETTLE_CYCLES > 0) ? $clog2(RESET_SETTLE_CYCLES + 1) : 1;

    exec_result_t     result_q;
    logic [CNT_W-1:0] settle_cnt;
    logic             settle_done;

    assign settle_done = (settle_cnt == CNT_W'(RESET_SETTLE_CYCLES));

    always_ff @(posedge clk_i)
    begin
        if (!resetn_i)
        begin
            result_q   <= '0;
            settle_cnt <= '0;
        end
        else
        begin
            result_q <= result_i;                // Captures even under halt
            if (halt_i)
                result_q.rd_write_en <= 1'b0;
            if (!settle_done)
                settle_cnt <= settle_cnt + 1'b1;
        end
    end

    // Enables held off until the settle count is reached
    always_comb
    begin
        result_o             = result_q;
        result_o.rd_write_en = result_q.rd_write_en & settle_done;
        result_o.branch_en   = result_q.branch_en & settle_done;
    end

endmodule

`default_nettype wire

// ==== design/instr_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_exec #(
    parameter int unsigned RESET_SETTLE_CYCLES = 2
) (
    input  logic                      clk_i,
    input  logic                      resetn_i,
    input  logic                      halt_i,
    input  rv_exec_pkg::exec_in_t     instr_i,   // Decoded instruction
    output rv_exec_pkg::exec_result_t result_o   // One cycle after instr_i
);
    import rv_exec_pkg::*;

    exec_ctrl_t   ctrl;
    exec_result_t result_comb;

    exec_decode u_decode (
        .opcode_i (instr_i.opcode),
        .funct3_i (instr_i.funct3),
        .funct7_i (instr_i.funct7),
        .ctrl_o   (ctrl)
    );

    exec_datapath u_datapath (
        .instr_i  (instr_i),
        .ctrl_i   (ctrl),
        .result_o (result_comb)
    );

    exec_stage_reg #(
        .RESET_SETTLE_CYCLES (RESET_SETTLE_CYCLES)
    ) u_stage_reg (
        .clk_i    (clk_i),
        .resetn_i (resetn_i),
        .halt_i   (halt_i),
        .result_i (result_comb),
        .result_o (result_o)
    );

endmodule

`default_nettype wire

// ==== sim/exec_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_checker #(
    parameter int unsigned SETTLE_CYCLES = 2
) (
    input  logic                      clk_i,
    input  logic                      resetn_i,
    input  rv_exec_pkg::exec_result_t result_i,      // DUT output
    input  logic                      exp_valid_i,
    input  logic                      exp_care_i,    // Compare rd_data too
    input  rv_exec_pkg::exec_result_t exp_result_i,
    input  string                     exp_label_i,
    output int                        pass_cnt_o,
    output int                        fail_cnt_o
);
    import rv_exec_pkg::*;

    typedef struct packed {
        logic         care;
        exec_result_t exp;
    } pending_t;

    pending_t pend_q[$];
    string    label_q[$];
    int       pass_cnt   = 0;
    int       fail_cnt   = 0;
    int       settle_cnt = 0;
    logic     reset_seen = 1'b0;
    logic     reset_bad  = 1'b0;
    logic     settle_bad = 1'b0;

    assign pass_cnt_o = pass_cnt;
    assign fail_cnt_o = fail_cnt;

    function automatic logic field_ok(input string name, input logic [31:0] got,
                                      input logic [31:0] want);
        if (got !== want)
        begin
            $display("Error at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, got, want);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic report(input string label, input logic ok);
        if (ok)
        begin
            pass_cnt++;
            $display("test %s: PASS", label);
        end
        else
        begin
            fail_cnt++;
            $display("test %s: FAIL", label);
        end
    endtask

    // --------------------------------------------------
    // Expectation queue, one entry per captured item
    // --------------------------------------------------
    always @(posedge clk_i)
    begin : capture
        pending_t p;
        if (exp_valid_i)
        begin
            p.care = exp_care_i;
            p.exp  = exp_result_i;
            pend_q.push_back(p);
            label_q.push_back(exp_label_i);
        end
    end

    // --------------------------------------------------
    // Compare mid cycle, where result_o is stable
    // --------------------------------------------------
    always @(negedge clk_i)
    begin : compare
        pending_t p;
        logic     ok;
        ok = 1'b1;
        if (!resetn_i)
        begin
            reset_seen = 1'b1;
            if (result_i !== '0)
            begin
                $display("Error at time %0t: result_o is 0x%0h, expected 0x0",
                         $time, result_i);
                reset_bad = 1'b1;
            end
        end
        else if (settle_cnt < SETTLE_CYCLES)
        begin
            if (settle_cnt == 0)
            begin
                if (!reset_seen)
                    $display("Reset was never seen low before it was released");
                report("reset", reset_seen && !reset_bad);
            end
            // Enables held off right after release
            if (!field_ok("rd_write_en", 32'(result_i.rd_write_en), 32'h0))
                settle_bad = 1'b1;
            if (!field_ok("branch_en", 32'(result_i.branch_en), 32'h0))
                settle_bad = 1'b1;
            settle_cnt++;
            if (settle_cnt == SETTLE_CYCLES)
                report("settle", !settle_bad);
        end
        else if (pend_q.size() > 0)
        begin
            p = pend_q.pop_front();
            ok &= field_ok("branch_en", 32'(result_i.branch_en), 32'(p.exp.branch_en));
            ok &= field_ok("branch_addr", result_i.branch_addr, p.exp.branch_addr);
            ok &= field_ok("rd_addr", 32'(result_i.rd_addr), 32'(p.exp.rd_addr));
            ok &= field_ok("rd_write_en", 32'(result_i.rd_write_en),
                           32'(p.exp.rd_write_en));
            if (p.care)
                ok &= field_ok("rd_data", result_i.rd_data, p.exp.rd_data);
            report(label_q.pop_front(), ok);
        end
    end

endmodule

`default_nettype wire

// ==== sim/instr_exec_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_exec_tb;
    import rv_exec_pkg::*;

    localparam int unsigned SETTLE_CYCLES = 2;
    localparam int          WAIT_LIMIT    = 200;    // Cycles per wait loop

    typedef struct packed {
        exec_in_t     instr;
        logic         halt;
        logic         care;     // rd_data is defined for this row
        exec_result_t exp;
    } row_t;

    logic         clk_i;
    logic         resetn_i;
    logic         halt_i;
    exec_in_t     instr_i;
    exec_result_t result_o;
    logic         exp_valid;
    logic         exp_care;
    exec_result_t exp_result;
    string        exp_label;
    int           pass_cnt;
    int           fail_cnt;

    row_t  table_q[$];
    string label_q[$];

    instr_exec #(
        .RESET_SETTLE_CYCLES (SETTLE_CYCLES)
    ) UUT (
        .clk_i    (clk_i),
        .resetn_i (resetn_i),
        .halt_i   (halt_i),
        .instr_i  (instr_i),
        .result_o (result_o)
    );

    exec_checker #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) u_checker (
        .clk_i        (clk_i),
        .resetn_i     (resetn_i),
        .result_i     (result_o),
        .exp_valid_i  (exp_valid),
        .exp_care_i   (exp_care),
        .exp_result_i (exp_result),
        .exp_label_i  (exp_label),
        .pass_cnt_o   (pass_cnt),
        .fail_cnt_o   (fail_cnt)
    );

    // --------------------------------------------------
    // Table construction
    // --------------------------------------------------
    // Filler values differ per field so a wrong operand select shows up
    function automatic exec_in_t base_instr(input opcode_e op, input logic [2:0] f3,
                                            input logic [6:0] f7);
        exec_in_t ins;
        ins.pc       = 32'h0000_1000;
        ins.opcode   = op;
        ins.funct3   = f3;
        ins.funct7   = f7;
        ins.rd_addr  = 5'd5;
        ins.imm_i    = 32'h0000_0111;
        ins.imm_b    = 32'h0000_0222;
        ins.imm_u    = 32'h0003_3000;
        ins.imm_j    = 32'h0000_0444;
        ins.rs1_data = 32'h0000_0055;
        ins.rs2_data = 32'h0000_0066;
        return ins;
    endfunction

    function automatic exec_result_t make_exp(input logic br, input logic [31:0] addr,
                                              input logic we, input logic [31:0] data);
        exec_result_t r;
        r.branch_en   = br;
        r.branch_addr = addr;
        r.rd_addr     = 5'd5;
        r.rd_write_en = we;
        r.rd_data     = data;
        return r;
    endfunction

    task automatic add_row(input string label, input exec_in_t ins, input logic halt,
                           input logic care, input exec_result_t exp);
        row_t row;
        row.instr = ins;
        row.halt  = halt;
        row.care  = care;
        row.exp   = exp;
        table_q.push_back(row);
        label_q.push_back(label);
    endtask

    task automatic alu_row(input string label, input opcode_e op, input logic [2:0] f3,
                           input logic [6:0] f7, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] res);
        exec_in_t ins;
        ins          = base_instr(op, f3, f7);
        ins.rs1_data = a;
        if (op == OP)
            ins.rs2_data = b;
        else
            ins.imm_i = b;
        add_row(label, ins, 1'b0, 1'b1, make_exp(1'b0, 32'h0, 1'b1, res));
    endtask

    // pc 0x1000 with imm_b of -16 targets 0x0FF0
    task automatic br_row(input string label, input logic [2:0] f3, input logic [31:0] a,
                          input logic [31:0] b, input logic taken);
        exec_in_t ins;
        ins          = base_instr(BRANCH, f3, FN7_BASE);
        ins.rs1_data = a;
        ins.rs2_data = b;
        ins.imm_b    = 32'hFFFF_FFF0;
        add_row(label, ins, 1'b0, 1'b0,
                make_exp(taken, taken ? 32'h0000_0FF0 : 32'h0, 1'b0, 32'h0));
    endtask

    task automatic fill_table();
        exec_in_t ins;
        alu_row("add", OP, ADD_SUB, FN7_BASE, 32'h7FFF_FFFF, 32'h0000_0001, 32'h8000_0000);
        alu_row("sub", OP, ADD_SUB, FN7_ALT, 32'h0000_0003, 32'h0000_0005, 32'hFFFF_FFFE);
        alu_row("sll", OP, SLL, FN7_BASE, 32'h0000_0001, 32'h0000_0024, 32'h0000_0010);
        alu_row("srl", OP, SRL_SRA, FN7_BASE, 32'h8000_0000, 32'h0000_001F, 32'h0000_0001);
        alu_row("sra", OP, SRL_SRA, FN7_ALT, 32'h8000_0000, 32'h0000_0004, 32'hF800_0000);
        alu_row("slt", OP, SLT, FN7_BASE, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001);
        alu_row("sltu", OP, SLTU, FN7_BASE, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000);
        alu_row("xor", OP, XOR, FN7_BASE, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'h0FF0_0FF0);
        alu_row("or", OP, OR, FN7_BASE, 32'hF0F0_0000, 32'h0000_0F0F, 32'hF0F0_0F0F);
        alu_row("and", OP, AND, FN7_BASE, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'hF000_F000);
        alu_row("addi", OP_IMM, ADD_SUB, 7'h7F, 32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF);
        // Unsigned or rs2 compare would give 1
        alu_row("slti", OP_IMM, SLT, 7'h3F, 32'h0000_0010, 32'hFFFF_F800, 32'h0000_0000);
        alu_row("srai", OP_IMM, SRL_SRA, FN7_ALT, 32'h8000_0000, 32'h0000_041F, 32'hFFFF_FFFF);
        br_row("beq_t", BEQ, 32'h0000_0005, 32'h0000_0005, 1'b1);
        br_row("beq_n", BEQ, 32'h0000_0005, 32'h0000_0006, 1'b0);
        br_row("bne_t", BNE, 32'h0000_0005, 32'h0000_0006, 1'b1);
        br_row("bne_n", BNE, 32'h0000_0005, 32'h0000_0005, 1'b0);
        br_row("blt_t", BLT, 32'hFFFF_FFFF, 32'h0000_0001, 1'b1);
        br_row("blt_n", BLT, 32'h0000_0001, 32'hFFFF_FFFF, 1'b0);
        br_row("bge_t", BGE, 32'h0000_0001, 32'hFFFF_FFFF, 1'b1);
        br_row("bge_n", BGE, 32'hFFFF_FFFF, 32'h0000_0001, 1'b0);
        br_row("bltu_t", BLTU, 32'h0000_0001, 32'hFFFF_FFFF, 1'b1);
        br_row("bltu_n", BLTU, 32'hFFFF_FFFF, 32'h0000_0001, 1'b0);
        br_row("bgeu_t", BGEU, 32'hFFFF_FFFF, 32'h0000_0001, 1'b1);
        br_row("bgeu_n", BGEU, 32'h0000_0001, 32'hFFFF_FFFF, 1'b0);
        ins       = base_instr(JAL, 3'b000, FN7_BASE);
        ins.imm_j = 32'h0000_0800;
        add_row("jal", ins, 1'b0, 1'b1, make_exp(1'b1, 32'h0000_1800, 1'b1, 32'h0000_1004));
        ins          = base_instr(JALR, 3'b000, FN7_BASE);
        ins.rs1_data = 32'h0000_2003;
        ins.imm_i    = 32'h0000_0010;                  // Sum 0x2013 has bit 0 cleared
        add_row("jalr", ins, 1'b0, 1'b1, make_exp(1'b1, 32'h0000_2012, 1'b1, 32'h0000_1004));
        ins       = base_instr(LUI, 3'b000, FN7_BASE);
        ins.imm_u = 32'hABCD_E000;
        add_row("lui", ins, 1'b0, 1'b1, make_exp(1'b0, 32'h0, 1'b1, 32'hABCD_E000));
        ins       = base_instr(AUIPC, 3'b000, FN7_BASE);
        ins.imm_u = 32'h0001_2000;
        add_row("auipc", ins, 1'b0, 1'b1, make_exp(1'b0, 32'h0, 1'b1, 32'h0001_3000));
        ins          = base_instr(OP, ADD_SUB, FN7_BASE);
        ins.rs1_data = 32'h0000_0010;
        ins.rs2_data = 32'h0000_0020;
        add_row("halt", ins, 1'b1, 1'b1, make_exp(1'b0, 32'h0, 1'b0, 32'h0000_0030));
        ins = base_instr(OP, ADD_SUB, 7'h01);         // MUL space lies outside RV32I
        add_row("bad_f7", ins, 1'b0, 1'b0, make_exp(1'b0, 32'h0, 1'b0, 32'h0));
        ins = base_instr(LOAD, 3'b010, FN7_BASE);
        add_row("load", ins, 1'b0, 1'b0, make_exp(1'b0, 32'h0, 1'b0, 32'h0));
        ins = base_instr(opcode_e'(7'h7F), 3'b000, FN7_BASE);
        add_row("bad_op", ins, 1'b0, 1'b0, make_exp(1'b0, 32'h0, 1'b0, 32'h0));
    endtask

    // --------------------------------------------------
    // Clock, reset and driver
    // --------------------------------------------------
    initial
    begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial
    begin
        resetn_i = 1'b0;
        repeat (10) @(posedge clk_i);
        #2;
        resetn_i = 1'b1;
    end

    initial
    begin : driver
        int   waited;
        int   settled;
        logic timed_out;
        fill_table();
        instr_i    = base_instr(OP, ADD_SUB, FN7_BASE);   // Valid ADD through settle
        halt_i     = 1'b0;
        exp_valid  = 1'b0;
        exp_care   = 1'b0;
        exp_result = '0;
        exp_label  = "";
        timed_out  = 1'b0;
        waited     = 0;
        settled    = 0;
        while (settled < SETTLE_CYCLES && !timed_out)
        begin
            @(posedge clk_i);
            if (resetn_i)
                settled++;
            waited++;
            if (waited > WAIT_LIMIT)
            begin
                $display("Timeout: reset release and settle not seen in %0d cycles",
                         WAIT_LIMIT);
                timed_out = 1'b1;
            end
        end
        if (!timed_out)
        begin
            foreach (table_q[i])
            begin
                #2;
                instr_i    = table_q[i].instr;
                halt_i     = table_q[i].halt;
                exp_care   = table_q[i].care;
                exp_result = table_q[i].exp;
                exp_label  = label_q[i];
                exp_valid  = 1'b1;
                @(posedge clk_i);
            end
            #2;
            exp_valid = 1'b0;
            halt_i    = 1'b0;
            waited    = 0;
            // Reset and settle tests come on top of the table rows
            while (pass_cnt + fail_cnt < table_q.size() + 2 && !timed_out)
            begin
                @(posedge clk_i);
                waited++;
                if (waited > WAIT_LIMIT)
                begin
                    $display("Timeout: checker reported %0d of %0d tests in %0d cycles",
                             pass_cnt + fail_cnt, table_q.size() + 2, WAIT_LIMIT);
                    timed_out = 1'b1;
                end
            end
        end
        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (!timed_out && fail_cnt == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
design/rv_exec_pkg.sv
design/exec_decode.sv
design/exec_alu.sv
design/exec_datapath.sv
design/exec_stage_reg.sv
design/instr_exec.sv
sim/exec_checker.sv
sim/instr_exec_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary -j 0
TOP       := instr_exec_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Test completed successfully
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
